/* hello_pkg.sv */
// Register map, FSM encodings and CNT_CTRL/CNT_STATUS bit layout; the status layout assumes CNT_W <= 16
package hello_pkg;

  // ----------------------------------------------------------------------
  // Register byte addresses on the OCL AXI4-Lite port
  // ----------------------------------------------------------------------
  typedef enum logic [31:0] {
    HELLO_WORLD_ADDR = 32'h0000_0500,
    VLED_ADDR        = 32'h0000_0504,
    CNT_CTRL_ADDR    = 32'h0000_0508,
    TICK_VALUE_ADDR  = 32'h0000_050C,
    LOAD_VALUE_ADDR  = 32'h0000_0510,
    WATERMARK_ADDR   = 32'h0000_0514,
    CNT_STATUS_ADDR  = 32'h0000_0518
  } reg_addr_e;

  // Write channel FSM
  typedef enum logic [1:0] {
    WR_IDLE,
    WR_DATA,
    WR_RESP
  } wr_state_e;

  // Returned for any address outside the map
  localparam logic [31:0] UNIMPLEMENTED_VALUE = 32'hDEAD_BEEF;

  // CNT_CTRL fields; clear and load are write-only pulses
  localparam int CTRL_ENABLE_BIT  = 0;
  localparam int CTRL_ONESHOT_BIT = 1;
  localparam int CTRL_CLEAR_BIT   = 2;
  localparam int CTRL_LOAD_BIT    = 3;

  // Watermark flag in CNT_STATUS, count sits below it
  localparam int STATUS_GE_BIT = 16;

  localparam logic [31:0] HELLO_RESET_VALUE = 32'h0000_0000;
  localparam logic [1:0]  RESP_OKAY         = 2'b00;

endpackage

/* axil_slave.sv */
// Single outstanding write and read, full-word writes only (no wstrb); no address decode in here
`timescale 1ns/1ps

module axil_slave (
  input  logic        clk_main_a0,
  input  logic        rst_main_n_sync,
  input  logic        awvalid,
  input  logic [31:0] awaddr,
  output logic        awready,
  input  logic        wvalid,
  input  logic [31:0] wdata,
  output logic        wready,
  output logic        bvalid,
  input  logic        bready,
  input  logic        arvalid,
  input  logic [31:0] araddr,
  output logic        arready,
  output logic        rvalid,
  output logic [31:0] rdata,
  input  logic        rready,
  output logic        reg_wr_en,
  output logic [31:0] reg_wr_addr,
  output logic [31:0] reg_wr_data,
  output logic        reg_rd_en,
  output logic [31:0] reg_rd_addr,
  input  logic [31:0] reg_rd_data
);

  hello_pkg::wr_state_e wr_state_q;
  logic [$bits(hello_pkg::reg_addr_e)-1:0] wr_addr_q;
  logic [$bits(hello_pkg::reg_addr_e)-1:0] rd_addr_q;
  // Stage 0 is the read strobe, stage 1 waits for the registered data
  logic [1:0] rd_pipe_q;
  logic       ready_en_q;

  // ----------------------------------------------------------------------
  // Write path
  // ----------------------------------------------------------------------
  assign awready     = ready_en_q && (wr_state_q == hello_pkg::WR_IDLE);
  assign wready      = (wr_state_q == hello_pkg::WR_DATA);
  assign bvalid      = (wr_state_q == hello_pkg::WR_RESP);
  assign reg_wr_en   = wvalid && wready;
  assign reg_wr_addr = wr_addr_q;
  assign reg_wr_data = wdata;

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      wr_state_q <= hello_pkg::WR_IDLE;
      ready_en_q <= 1'b0;
    end else begin
      ready_en_q <= 1'b1;
      case (wr_state_q)
        hello_pkg::WR_IDLE: begin
          if (awvalid && awready) wr_state_q <= hello_pkg::WR_DATA;
        end
        hello_pkg::WR_DATA: begin
          if (wvalid) wr_state_q <= hello_pkg::WR_RESP;
        end
        hello_pkg::WR_RESP: begin
          if (bready) wr_state_q <= hello_pkg::WR_IDLE;
        end
        default: wr_state_q <= hello_pkg::WR_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_main_a0) begin
    if (awvalid && awready) wr_addr_q <= awaddr;
  end

  // ----------------------------------------------------------------------
  // Read path, rvalid two cycles after the ar handshake
  // ----------------------------------------------------------------------
  assign arready     = ready_en_q && (rd_pipe_q == 2'b00) && !rvalid;
  assign reg_rd_en   = rd_pipe_q[0];
  assign reg_rd_addr = rd_addr_q;

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      rd_pipe_q <= 2'b00;
      rvalid    <= 1'b0;
    end else begin
      rd_pipe_q <= {rd_pipe_q[0], arvalid && arready};
      if (rd_pipe_q[1]) begin
        rvalid <= 1'b1;
      end else if (rvalid && rready) begin
        rvalid <= 1'b0;
      end
    end
  end

  // Data held until the r handshake since no new read can start
  always_ff @(posedge clk_main_a0) begin
    if (arvalid && arready) rd_addr_q <= araddr;
    if (rd_pipe_q[1]) rdata <= reg_rd_data;
  end

endmodule

/* hello_regs.sv */
// Register file behind the slave; CNT_W must be at most 16 so the count fits below the GE flag
`timescale 1ns/1ps

module hello_regs #(
  parameter int CNT_W = 16
) (
  input  logic             clk_main_a0,
  input  logic             rst_main_n_sync,
  input  logic             reg_wr_en,
  input  logic [31:0]      reg_wr_addr,
  input  logic [31:0]      reg_wr_data,
  input  logic             reg_rd_en,
  input  logic [31:0]      reg_rd_addr,
  output logic [31:0]      reg_rd_data,
  output logic [CNT_W-1:0] hello_low,
  input  logic [CNT_W-1:0] vled_shadow,
  output logic             cnt_enable,
  output logic             cnt_oneshot,
  output logic             cnt_clear,
  output logic             cnt_load,
  output logic [7:0]       tick_value,
  output logic [CNT_W-1:0] load_value,
  output logic [CNT_W-1:0] watermark,
  input  logic [CNT_W-1:0] cnt_value,
  input  logic             cnt_ge_watermark
);

  logic [31:0] hello_q;
  logic [31:0] hello_swapped;
  logic [31:0] rd_mux;

  assign hello_low     = hello_q[CNT_W-1:0];
  assign hello_swapped = {hello_q[7:0], hello_q[15:8], hello_q[23:16], hello_q[31:24]};

  // ----------------------------------------------------------------------
  // Write decode
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      hello_q     <= hello_pkg::HELLO_RESET_VALUE;
      cnt_enable  <= 1'b0;
      cnt_oneshot <= 1'b0;
      cnt_clear   <= 1'b0;
      cnt_load    <= 1'b0;
      tick_value  <= '0;
      load_value  <= '0;
      watermark   <= '0;
    end else begin
      // Clear and load live for one cycle only
      cnt_clear <= 1'b0;
      cnt_load  <= 1'b0;
      if (reg_wr_en) begin
        case (reg_wr_addr)
          hello_pkg::HELLO_WORLD_ADDR: hello_q <= reg_wr_data;
          hello_pkg::CNT_CTRL_ADDR: begin
            cnt_enable  <= reg_wr_data[hello_pkg::CTRL_ENABLE_BIT];
            cnt_oneshot <= reg_wr_data[hello_pkg::CTRL_ONESHOT_BIT];
            cnt_clear   <= reg_wr_data[hello_pkg::CTRL_CLEAR_BIT];
            cnt_load    <= reg_wr_data[hello_pkg::CTRL_LOAD_BIT];
          end
          hello_pkg::TICK_VALUE_ADDR: tick_value <= reg_wr_data[7:0];
          hello_pkg::LOAD_VALUE_ADDR: load_value <= reg_wr_data[CNT_W-1:0];
          hello_pkg::WATERMARK_ADDR:  watermark  <= reg_wr_data[CNT_W-1:0];
          // VLED and CNT_STATUS are read-only
          default: ;
        endcase
      end
    end
  end

  // ----------------------------------------------------------------------
  // Read mux, registered on the strobe
  // ----------------------------------------------------------------------
  always_comb begin
    rd_mux = '0;
    case (reg_rd_addr)
      hello_pkg::HELLO_WORLD_ADDR: rd_mux = hello_swapped;
      hello_pkg::VLED_ADDR:        rd_mux = 32'(vled_shadow);
      hello_pkg::CNT_CTRL_ADDR: begin
        rd_mux[hello_pkg::CTRL_ENABLE_BIT]  = cnt_enable;
        rd_mux[hello_pkg::CTRL_ONESHOT_BIT] = cnt_oneshot;
      end
      hello_pkg::TICK_VALUE_ADDR:  rd_mux = 32'(tick_value);
      hello_pkg::LOAD_VALUE_ADDR:  rd_mux = 32'(load_value);
      hello_pkg::WATERMARK_ADDR:   rd_mux = 32'(watermark);
      hello_pkg::CNT_STATUS_ADDR: begin
        rd_mux = 32'(cnt_value);
        rd_mux[hello_pkg::STATUS_GE_BIT] = cnt_ge_watermark;
      end
      default: rd_mux = hello_pkg::UNIMPLEMENTED_VALUE;
    endcase
  end

  always_ff @(posedge clk_main_a0) begin
    if (reg_rd_en) reg_rd_data <= rd_mux;
  end

endmodule

/* vled_mask.sv */
// LED width equals CNT_W; DIP inputs are asynchronous and pass SYNC_STAGES flops before the mask
`timescale 1ns/1ps

module vled_mask #(
  parameter int CNT_W       = 16,
  parameter int SYNC_STAGES = 2
) (
  input  logic             clk_main_a0,
  input  logic             rst_main_n_sync,
  input  logic [CNT_W-1:0] hello_low,
  input  logic [CNT_W-1:0] status_vdip,
  output logic [CNT_W-1:0] vled_shadow,
  output logic [CNT_W-1:0] status_vled
);

  logic [SYNC_STAGES-1:0][CNT_W-1:0] vdip_sync_q;

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      vdip_sync_q <= '0;
      vled_shadow <= '0;
      status_vled <= '0;
    end else begin
      // DIP synchronizer chain, stage 0 samples the pins
      vdip_sync_q[0] <= status_vdip;
      for (int i = 1; i < SYNC_STAGES; i++) begin
        vdip_sync_q[i] <= vdip_sync_q[i-1];
      end
      // Shadow follows the low half of hello-world
      vled_shadow <= hello_low;
      status_vled <= vled_shadow & vdip_sync_q[SYNC_STAGES-1];
    end
  end

endmodule

/* tick_counter.sv */
// Prescaled counter; tick_value 0 counts every enabled cycle, one-shot saturates at all-ones
`timescale 1ns/1ps

module tick_counter #(
  parameter int CNT_W = 16
) (
  input  logic             clk_main_a0,
  input  logic             rst_main_n_sync,
  input  logic             cnt_enable,
  input  logic             cnt_oneshot,
  input  logic             cnt_clear,
  input  logic             cnt_load,
  input  logic [7:0]       tick_value,
  input  logic [CNT_W-1:0] load_value,
  input  logic [CNT_W-1:0] watermark,
  output logic [CNT_W-1:0] cnt_value,
  output logic             cnt_ge_watermark
);

  logic [7:0] presc_q;
  logic       tick;
  logic       saturated;

  // Greater-or-equal so a lowered tick_value does not stall the prescaler
  assign tick      = (presc_q >= tick_value);
  assign saturated = cnt_oneshot && (cnt_value == '1);

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      presc_q          <= '0;
      cnt_value        <= '0;
      cnt_ge_watermark <= 1'b0;
    end else begin
      if (cnt_clear) begin
        presc_q   <= '0;
        cnt_value <= '0;
      end else if (cnt_load) begin
        cnt_value <= load_value;
      end else if (cnt_enable) begin
        if (tick) begin
          presc_q <= '0;
          if (!saturated) cnt_value <= cnt_value + 1'b1;
        end else begin
          presc_q <= presc_q + 1'b1;
        end
      end
      // Flag lags the count by one cycle
      cnt_ge_watermark <= (cnt_value >= watermark);
    end
  end

endmodule

/* cl_hello_top.sv */
// OCL register block top; responses are always OKAY and CNT_W also sets the LED/DIP width
`timescale 1ns/1ps

module cl_hello_top #(
  parameter int CNT_W       = 16,
  parameter int SYNC_STAGES = 2
) (
  input  logic             clk_main_a0,
  input  logic             rst_main_n_sync,
  input  logic             ocl_awvalid,
  input  logic [31:0]      ocl_awaddr,
  output logic             ocl_awready,
  input  logic             ocl_wvalid,
  input  logic [31:0]      ocl_wdata,
  output logic             ocl_wready,
  output logic             ocl_bvalid,
  output logic [1:0]       ocl_bresp,
  input  logic             ocl_bready,
  input  logic             ocl_arvalid,
  input  logic [31:0]      ocl_araddr,
  output logic             ocl_arready,
  output logic             ocl_rvalid,
  output logic [31:0]      ocl_rdata,
  output logic [1:0]       ocl_rresp,
  input  logic             ocl_rready,
  input  logic [CNT_W-1:0] status_vdip,
  output logic [CNT_W-1:0] status_vled
);

  // ----------------------------------------------------------------------
  // Internal register bus and counter wiring
  // ----------------------------------------------------------------------
  logic             reg_wr_en;
  logic [31:0]      reg_wr_addr;
  logic [31:0]      reg_wr_data;
  logic             reg_rd_en;
  logic [31:0]      reg_rd_addr;
  logic [31:0]      reg_rd_data;
  logic [CNT_W-1:0] hello_low;
  logic [CNT_W-1:0] vled_shadow;
  logic             cnt_enable;
  logic             cnt_oneshot;
  logic             cnt_clear;
  logic             cnt_load;
  logic [7:0]       tick_value;
  logic [CNT_W-1:0] load_value;
  logic [CNT_W-1:0] watermark;
  logic [CNT_W-1:0] cnt_value;
  logic             cnt_ge_watermark;

  assign ocl_bresp = hello_pkg::RESP_OKAY;
  assign ocl_rresp = hello_pkg::RESP_OKAY;

  axil_slave slave_i (
    .clk_main_a0 (clk_main_a0),      .rst_main_n_sync (rst_main_n_sync),
    .awvalid     (ocl_awvalid),      .awaddr          (ocl_awaddr),
    .awready     (ocl_awready),      .wvalid          (ocl_wvalid),
    .wdata       (ocl_wdata),        .wready          (ocl_wready),
    .bvalid      (ocl_bvalid),       .bready          (ocl_bready),
    .arvalid     (ocl_arvalid),      .araddr          (ocl_araddr),
    .arready     (ocl_arready),      .rvalid          (ocl_rvalid),
    .rdata       (ocl_rdata),        .rready          (ocl_rready),
    .reg_wr_en   (reg_wr_en),        .reg_wr_addr     (reg_wr_addr),
    .reg_wr_data (reg_wr_data),      .reg_rd_en       (reg_rd_en),
    .reg_rd_addr (reg_rd_addr),      .reg_rd_data     (reg_rd_data)
  );

  hello_regs #(.CNT_W(CNT_W)) regs_i (
    .clk_main_a0 (clk_main_a0),      .rst_main_n_sync  (rst_main_n_sync),
    .reg_wr_en   (reg_wr_en),        .reg_wr_addr      (reg_wr_addr),
    .reg_wr_data (reg_wr_data),      .reg_rd_en        (reg_rd_en),
    .reg_rd_addr (reg_rd_addr),      .reg_rd_data      (reg_rd_data),
    .hello_low   (hello_low),        .vled_shadow      (vled_shadow),
    .cnt_enable  (cnt_enable),       .cnt_oneshot      (cnt_oneshot),
    .cnt_clear   (cnt_clear),        .cnt_load         (cnt_load),
    .tick_value  (tick_value),       .load_value       (load_value),
    .watermark   (watermark),        .cnt_value        (cnt_value),
    .cnt_ge_watermark (cnt_ge_watermark)
  );

  vled_mask #(.CNT_W(CNT_W), .SYNC_STAGES(SYNC_STAGES)) vled_i (
    .clk_main_a0 (clk_main_a0),      .rst_main_n_sync (rst_main_n_sync),
    .hello_low   (hello_low),        .status_vdip     (status_vdip),
    .vled_shadow (vled_shadow),      .status_vled     (status_vled)
  );

  tick_counter #(.CNT_W(CNT_W)) cnt_i (
    .clk_main_a0 (clk_main_a0),      .rst_main_n_sync (rst_main_n_sync),
    .cnt_enable  (cnt_enable),       .cnt_oneshot     (cnt_oneshot),
    .cnt_clear   (cnt_clear),        .cnt_load        (cnt_load),
    .tick_value  (tick_value),       .load_value      (load_value),
    .watermark   (watermark),        .cnt_value       (cnt_value),
    .cnt_ge_watermark (cnt_ge_watermark)
  );

endmodule

/* hello_chk.sv */
// Bound into axil_slave; checks OCL handshake rules and counts every assertion failure
`timescale 1ns/1ps

module hello_chk (
  input logic                 clk_main_a0,
  input logic                 rst_main_n_sync,
  input hello_pkg::wr_state_e wr_state_q,
  input logic                 awready,
  input logic                 bvalid,
  input logic                 bready,
  input logic                 rvalid,
  input logic                 rready,
  input logic [31:0]          rdata,
  input logic                 reg_wr_en
);

  int unsigned fail_count = 0;

  // ----------------------------------------------------------------------
  // Handshake rules
  // ----------------------------------------------------------------------
  aw_only_idle: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    (wr_state_q != hello_pkg::WR_IDLE) |-> !awready)
    else begin
      fail_count++;
      $error("awready high outside WR_IDLE");
    end

  b_holds: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    (bvalid && !bready) |=> bvalid)
    else begin
      fail_count++;
      $error("bvalid dropped before the b handshake");
    end

  r_holds: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    (rvalid && !rready) |=> (rvalid && $stable(rdata)))
    else begin
      fail_count++;
      $error("rvalid or rdata changed before the r handshake");
    end

  // Write strobe is a single-cycle pulse
  wr_pulse: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    reg_wr_en |=> !reg_wr_en)
    else begin
      fail_count++;
      $error("reg_wr_en high for more than one cycle");
    end

endmodule

bind axil_slave hello_chk chk_i (
  .clk_main_a0 (clk_main_a0), .rst_main_n_sync (rst_main_n_sync),
  .wr_state_q  (wr_state_q),  .awready         (awready),
  .bvalid      (bvalid),      .bready          (bready),
  .rvalid      (rvalid),      .rready          (rready),
  .rdata       (rdata),       .reg_wr_en       (reg_wr_en)
);

/* tb_hello.sv */
// Testbench for cl_hello_top with default parameters; expected values assume CNT_W of 16
`timescale 1ns/1ps

module tb_hello;

  localparam int TIMEOUT = 64;
  localparam logic [1:0] AXI_OKAY = 2'b00;

  logic        clk_main_a0;
  logic        rst_main_n_sync;
  logic        ocl_awvalid;
  logic [31:0] ocl_awaddr;
  logic        ocl_awready;
  logic        ocl_wvalid;
  logic [31:0] ocl_wdata;
  logic        ocl_wready;
  logic        ocl_bvalid;
  logic [1:0]  ocl_bresp;
  logic        ocl_bready;
  logic        ocl_arvalid;
  logic [31:0] ocl_araddr;
  logic        ocl_arready;
  logic        ocl_rvalid;
  logic [31:0] ocl_rdata;
  logic [1:0]  ocl_rresp;
  logic        ocl_rready;
  logic [15:0] status_vdip;
  logic [15:0] status_vled;

  // Register map model
  logic [31:0] m_hello;
  logic        m_enable;
  logic        m_oneshot;
  logic [7:0]  m_tick;
  logic [15:0] m_load;
  logic [15:0] m_wmark;
  logic [15:0] m_count;

  // Pending comparisons, filled by the stimulus
  string       chk_name_q[$];
  logic [31:0] chk_exp_q[$];
  logic [31:0] chk_act_q[$];
  int          checks = 0;
  int          errors = 0;
  int          timeouts = 0;

  cl_hello_top dut_i (.*);

  initial begin
    clk_main_a0 = 1'b0;
    forever #10 clk_main_a0 = ~clk_main_a0;
  end

  // ----------------------------------------------------------------------
  // Reference model
  // ----------------------------------------------------------------------
  function automatic logic [31:0] expected_read(input logic [31:0] addr);
    logic [31:0] v;
    v = '0;
    case (addr)
      hello_pkg::HELLO_WORLD_ADDR: begin
        // Byte b of the read comes from byte 3-b of the stored word
        for (int b = 0; b < 4; b++) v[8*b +: 8] = m_hello[8*(3-b) +: 8];
      end
      hello_pkg::VLED_ADDR:       v[15:0] = m_hello[15:0];
      hello_pkg::CNT_CTRL_ADDR: begin
        v[hello_pkg::CTRL_ENABLE_BIT]  = m_enable;
        v[hello_pkg::CTRL_ONESHOT_BIT] = m_oneshot;
      end
      hello_pkg::TICK_VALUE_ADDR: v[7:0] = m_tick;
      hello_pkg::LOAD_VALUE_ADDR: v[15:0] = m_load;
      hello_pkg::WATERMARK_ADDR:  v[15:0] = m_wmark;
      hello_pkg::CNT_STATUS_ADDR: begin
        v[15:0] = m_count;
        v[hello_pkg::STATUS_GE_BIT] = (m_count >= m_wmark);
      end
      default: v = hello_pkg::UNIMPLEMENTED_VALUE;
    endcase
    return v;
  endfunction

  function automatic void model_write(input logic [31:0] addr, input logic [31:0] data);
    case (addr)
      hello_pkg::HELLO_WORLD_ADDR: m_hello = data;
      hello_pkg::CNT_CTRL_ADDR: begin
        m_enable  = data[hello_pkg::CTRL_ENABLE_BIT];
        m_oneshot = data[hello_pkg::CTRL_ONESHOT_BIT];
        if (data[hello_pkg::CTRL_CLEAR_BIT]) m_count = '0;
        else if (data[hello_pkg::CTRL_LOAD_BIT]) m_count = m_load;
      end
      hello_pkg::TICK_VALUE_ADDR: m_tick = data[7:0];
      hello_pkg::LOAD_VALUE_ADDR: m_load = data[15:0];
      hello_pkg::WATERMARK_ADDR:  m_wmark = data[15:0];
      default: ;
    endcase
  endfunction

  // Advance the modelled count over a number of enabled cycles
  function automatic void model_run(input int cycles);
    int ticks;
    ticks = m_enable ? cycles / (int'(m_tick) + 1) : 0;
    for (int i = 0; i < ticks; i++) begin
      if (!(m_oneshot && m_count == 16'hFFFF)) m_count = m_count + 16'd1;
    end
  endfunction

  function automatic void push_check(input string name, input logic [31:0] exp_v,
                                     input logic [31:0] act_v);
    chk_name_q.push_back(name);
    chk_exp_q.push_back(exp_v);
    chk_act_q.push_back(act_v);
  endfunction

  // ----------------------------------------------------------------------
  // OCL driver tasks
  // ----------------------------------------------------------------------
  function automatic logic probe(input string what);
    case (what)
      "awready": return ocl_awready;
      "wready":  return ocl_wready;
      "bvalid":  return ocl_bvalid;
      "arready": return ocl_arready;
      "rvalid":  return ocl_rvalid;
      default:   return 1'b0;
    endcase
  endfunction

  task automatic wait_for(input string what, output bit ok);
    int n;
    ok = 1'b0;
    for (n = 0; n < TIMEOUT; n++) begin
      @(negedge clk_main_a0);
      if (probe(what)) begin
        ok = 1'b1;
        break;
      end
    end
    if (!ok) begin
      timeouts++;
      errors++;
      $display("Timeout at %0t: %s did not rise within %0d cycles", $time, what, TIMEOUT);
    end
  endtask

  // Response must stay valid while ready is held low
  task automatic hold_response(input string what, input int stall);
    repeat (stall) begin
      @(negedge clk_main_a0);
      assert (probe(what)) else begin
        errors++;
        $display("At %0t: %s dropped before its handshake", $time, what);
      end
    end
  endtask

  task automatic axi_write(input logic [31:0] addr, input logic [31:0] data, input int stall);
    bit ok;
    @(posedge clk_main_a0);
    #1;
    ocl_awvalid = 1'b1;
    ocl_awaddr  = addr;
    wait_for("awready", ok);
    @(posedge clk_main_a0);
    #1;
    ocl_awvalid = 1'b0;
    if (!ok) return;
    ocl_wvalid = 1'b1;
    ocl_wdata  = data;
    wait_for("wready", ok);
    @(posedge clk_main_a0);
    #1;
    ocl_wvalid = 1'b0;
    if (!ok) return;
    wait_for("bvalid", ok);
    if (!ok) return;
    hold_response("bvalid", stall);
    @(posedge clk_main_a0);
    #1;
    ocl_bready = 1'b1;
    // Response sampled just before the accepting edge
    @(negedge clk_main_a0);
    push_check("ocl_bresp", 32'(AXI_OKAY), 32'(ocl_bresp));
    @(posedge clk_main_a0);
    #1;
    ocl_bready = 1'b0;
  endtask

  task automatic axi_read(input logic [31:0] addr, input int stall,
                          output logic [31:0] data, output bit ok);
    @(posedge clk_main_a0);
    #1;
    ocl_arvalid = 1'b1;
    ocl_araddr  = addr;
    wait_for("arready", ok);
    @(posedge clk_main_a0);
    #1;
    ocl_arvalid = 1'b0;
    if (!ok) return;
    wait_for("rvalid", ok);
    if (!ok) return;
    hold_response("rvalid", stall);
    @(posedge clk_main_a0);
    #1;
    ocl_rready = 1'b1;
    // Data sampled just before the accepting edge
    @(negedge clk_main_a0);
    data = ocl_rdata;
    push_check("ocl_rresp", 32'(AXI_OKAY), 32'(ocl_rresp));
    @(posedge clk_main_a0);
    #1;
    ocl_rready = 1'b0;
  endtask

  task automatic reg_write(input logic [31:0] addr, input logic [31:0] data, input int stall);
    axi_write(addr, data, stall);
    model_write(addr, data);
  endtask

  task automatic check_read(input logic [31:0] addr, input int stall);
    logic [31:0] exp_v;
    logic [31:0] act_v;
    bit          ok;
    exp_v = expected_read(addr);
    axi_read(addr, stall, act_v, ok);
    if (ok) push_check($sformatf("ocl_rdata[0x%03h]", addr), exp_v, act_v);
  endtask

  task automatic read_all_regs();
    hello_pkg::reg_addr_e a;
    a = a.first();
    repeat (a.num()) begin
      check_read(a, 0);
      a = a.next();
    end
  endtask

  // ----------------------------------------------------------------------
  // Comparing process
  // ----------------------------------------------------------------------
  initial begin
    string       name;
    logic [31:0] exp_v;
    logic [31:0] act_v;
    forever begin
      @(posedge clk_main_a0);
      while (chk_act_q.size() > 0) begin
        name  = chk_name_q.pop_front();
        exp_v = chk_exp_q.pop_front();
        act_v = chk_act_q.pop_front();
        checks++;
        assert (act_v === exp_v) else begin
          errors++;
          $display("CHECK FAILED at %0t: %s expected 0x%08h got 0x%08h",
                   $time, name, exp_v, act_v);
        end
      end
    end
  end

  // ----------------------------------------------------------------------
  // Stimulus
  // ----------------------------------------------------------------------
  initial begin
    logic [31:0] data;
    logic [15:0] load;
    logic [15:0] wm;
    int          n;
    int          asrt_fails;
    void'($urandom(32'h5ba2));
    rst_main_n_sync = 1'b0;
    ocl_awvalid = 1'b0;
    ocl_awaddr  = '0;
    ocl_wvalid  = 1'b0;
    ocl_wdata   = '0;
    ocl_bready  = 1'b0;
    ocl_arvalid = 1'b0;
    ocl_araddr  = '0;
    ocl_rready  = 1'b0;
    status_vdip = '0;
    m_hello = '0;
    m_enable = 1'b0;
    m_oneshot = 1'b0;
    m_tick = '0;
    m_load = '0;
    m_wmark = '0;
    m_count = '0;
    repeat (5) @(posedge clk_main_a0);
    #1;
    rst_main_n_sync = 1'b1;

    // Reset values
    @(negedge clk_main_a0);
    push_check("status_vled", 32'h0, 32'(status_vled));
    read_all_regs();

    // Byte swap
    repeat (8) begin
      data = $urandom;
      reg_write(hello_pkg::HELLO_WORLD_ADDR, data, 0);
      check_read(hello_pkg::HELLO_WORLD_ADDR, 0);
    end

    // Unmapped writes and reads
    reg_write(32'h0000_0600, $urandom, 0);
    reg_write(32'h0000_051C, $urandom, 0);
    read_all_regs();
    check_read(32'h0000_0600, 0);
    check_read(32'h0000_051C, 0);

    // LED shadow and DIP mask
    repeat (3) begin
      reg_write(hello_pkg::HELLO_WORLD_ADDR, $urandom, 0);
      check_read(hello_pkg::VLED_ADDR, 0);
      @(posedge clk_main_a0);
      #1;
      status_vdip = 16'($urandom);
      repeat (4) @(posedge clk_main_a0);
      @(negedge clk_main_a0);
      push_check("status_vled", 32'(m_hello[15:0] & status_vdip), 32'(status_vled));
    end

    // Load, watermark flag and clear with the counter stopped
    reg_write(hello_pkg::CNT_CTRL_ADDR, 32'h0, 0);
    load = 16'($urandom);
    reg_write(hello_pkg::LOAD_VALUE_ADDR, 32'(load), 0);
    reg_write(hello_pkg::CNT_CTRL_ADDR, 32'h1 << hello_pkg::CTRL_LOAD_BIT, 0);
    for (n = -1; n <= 1; n++) begin
      wm = load + 16'(n);
      reg_write(hello_pkg::WATERMARK_ADDR, 32'(wm), 0);
      check_read(hello_pkg::CNT_STATUS_ADDR, 0);
    end
    check_read(hello_pkg::CNT_CTRL_ADDR, 0);
    reg_write(hello_pkg::CNT_CTRL_ADDR, 32'h1 << hello_pkg::CTRL_CLEAR_BIT, 0);
    check_read(hello_pkg::CNT_STATUS_ADDR, 0);

    // One-shot saturation
    reg_write(hello_pkg::LOAD_VALUE_ADDR, 32'h0000_FFFE, 0);
    reg_write(hello_pkg::CNT_CTRL_ADDR, 32'h1 << hello_pkg::CTRL_LOAD_BIT, 0);
    reg_write(hello_pkg::TICK_VALUE_ADDR, 32'h0, 0);
    reg_write(hello_pkg::CNT_CTRL_ADDR, 32'h3, 0);
    repeat (20) @(posedge clk_main_a0);
    model_run(20);
    check_read(hello_pkg::CNT_CTRL_ADDR, 0);
    // With one-shot off too, only the stopped enable keeps the count
    reg_write(hello_pkg::CNT_CTRL_ADDR, 32'h0, 0);
    check_read(hello_pkg::CNT_STATUS_ADDR, 0);
    check_read(hello_pkg::CNT_STATUS_ADDR, 0);

    // Back-pressure on both response channels
    repeat (2) begin
      reg_write(hello_pkg::HELLO_WORLD_ADDR, $urandom, 6);
      check_read(hello_pkg::HELLO_WORLD_ADDR, 6);
    end

    for (n = 0; n < TIMEOUT && chk_act_q.size() > 0; n++) @(posedge clk_main_a0);
    if (chk_act_q.size() > 0) begin
      errors++;
      $display("Comparing process left %0d results unchecked", chk_act_q.size());
    end
    asrt_fails = int'(dut_i.slave_i.chk_i.fail_count);
    $display("Summary: %0d checks, %0d errors, %0d timeouts, %0d assertion failures",
             checks, errors, timeouts, asrt_fails);
    if (errors == 0 && asrt_fails == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

/* list.f */
hello_pkg.sv
axil_slave.sv
hello_regs.sv
vled_mask.sv
tick_counter.sv
cl_hello_top.sv
hello_chk.sv
tb_hello.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_hello
FILELIST = list.f

OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
LOG      = sim.log
PASS_MSG = All checks passed
SOURCES  = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) +verilator+error+limit+1000 | tee $(LOG)
	@grep -qx '$(PASS_MSG)' $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
